//--- dv/mem_subsys_tb.sv
/*
 * memory subsystem testbench
 * directed tests for writeback, CP0 access, translated store and load,
 * TLB miss, interrupts and exceptions carried in from execute
 */
`include "mem_config.svh"

module mem_subsys_tb import mem_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int N_TESTS = 6;
	localparam int TEST_CYCLES = 60;
	localparam int DRIVE_DELAY = 2;
	localparam int WAIT_LIMIT = 20;

	logic clk;
	logic rst;
	ex2mem_t ex2mem;
	logic [`MEM_INT_W-1:0] int_req;
	logic [`MEM_REGADDR_W-1:0] wb_addr;
	logic [31:0] wb_data;
	logic stall;
	logic flush;
	logic is_user_mode;
	logic exc_jmp_flag;
	logic [31:0] exc_jmp_dest;

	int errors;
	int checks;
	integer seed;

	mem_subsys DUT (
		.clk(clk), .rst(rst),
		.ex2mem(ex2mem), .int_req(int_req),
		.wb_addr(wb_addr), .wb_data(wb_data),
		.stall(stall), .flush(flush), .is_user_mode(is_user_mode),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + N_TESTS * TEST_CYCLES));
		$display("timeout: the tests did not finish in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

	// #########################################################################
	// helpers

	function automatic ex2mem_t make_bundle(input mem_op_e op, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] alu_result,
		input logic [`MEM_REGADDR_W-1:0] wb, input exc_code_e exc, input logic [31:0] epc);
		ex2mem_t b;
		b.op = op;
		b.addr = addr;
		b.data = data;
		b.alu_result = alu_result;
		b.wb_addr = wb;
		b.exc_code = exc;
		b.epc = epc;
		b.badvaddr = '0;
		return b;
	endfunction

	function automatic ex2mem_t idle_bundle();
		return make_bundle(OP_NONE, '0, '0, '0, '0, EXC_NONE, '0);
	endfunction

	// outputs are sampled at the same point where inputs are driven
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// one acceptance edge, then the bus falls back to an idle bundle
	task automatic issue(input ex2mem_t b);
		ex2mem = b;
		next_cycle();
		ex2mem = idle_bundle();
	endtask

	task automatic wait_ready(input string name, output int cycles);
		cycles = 0;
		while (stall && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		checks++;
		assert (!stall) else begin
			errors++;
			$display("%s: stall stayed high for %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	task automatic wait_flush(input string name);
		int cycles;
		cycles = 0;
		while (!flush && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		checks++;
		assert (flush) else begin
			errors++;
			$display("%s: flush never rose within %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	// the jump follows one cycle after flush
	task automatic check_jump(input string name);
		next_cycle();
		check_value({name, " flush drop"}, 1'b0, flush);
		check_value({name, " jump flag"}, 1'b1, exc_jmp_flag);
		check_value({name, " jump dest"}, `MEM_EXC_VECTOR, exc_jmp_dest);
		next_cycle();
		check_value({name, " jump pulse"}, 1'b0, exc_jmp_flag);
	endtask

	task automatic write_cp0(input string name, input int regnum, input logic [31:0] value);
		int stalled;
		issue(make_bundle(OP_WRITE_CP0, 32'(regnum), value, '0, 5'd4, EXC_NONE, '0));
		check_value({name, " wb_addr"}, '0, wb_addr);
		wait_ready(name, stalled);
		check_value({name, " stall cycles"}, 1, stalled);
	endtask

	task automatic read_cp0(input string name, input int regnum, output logic [31:0] value);
		issue(make_bundle(OP_READ_CP0, 32'(regnum), '0, '0, 5'd3, EXC_NONE, '0));
		check_value({name, " stall"}, 1'b0, stall);
		check_value({name, " wb_addr"}, 5'd3, wb_addr);
		value = wb_data;
	endtask

	task automatic apply_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		check_value("reset stall", 1'b0, stall);
		check_value("reset flush", 1'b0, flush);
		check_value("reset jump flag", 1'b0, exc_jmp_flag);
		check_value("reset wb_addr", '0, wb_addr);
		check_value("reset user mode", 1'b0, is_user_mode);
		rst = 1'b0;
		next_cycle();
	endtask

	// #########################################################################
	// tests

	task automatic test_writeback();
		int i;
		logic [31:0] value;
		logic [`MEM_REGADDR_W-1:0] reg_addr;
		for (i = 0; i < 4; i++) begin
			value = $random(seed);
			reg_addr = `MEM_REGADDR_W'(i * 7 + 1);
			issue(make_bundle(OP_NONE, '0, '0, value, reg_addr, EXC_NONE, '0));
			check_value("writeback wb_addr", reg_addr, wb_addr);
			check_value("writeback wb_data", value, wb_data);
			check_value("writeback stall", 1'b0, stall);
		end
	endtask

	task automatic test_cp0_roundtrip();
		logic [31:0] value;
		logic [31:0] readback;
		value = $random(seed);
		write_cp0("cp0 write entry hi", `MEM_CP0_ENTRY_HI, value);
		read_cp0("cp0 read entry hi", `MEM_CP0_ENTRY_HI, readback);
		check_value("cp0 round trip", value, readback);
	endtask

	task automatic test_store_load();
		logic [19:0] vpn;
		logic [19:0] pfn;
		logic [31:0] vaddr;
		logic [31:0] word;
		int stalled;
		vpn = 20'h00400;
		pfn = 20'h00012;
		vaddr = {vpn, 12'h3a4};
		word = $random(seed);
		write_cp0("tlb index", `MEM_CP0_INDEX, 32'd1);
		write_cp0("tlb entry hi", `MEM_CP0_ENTRY_HI, {vpn, 12'h000});
		// MIPS EntryLo with PFN at bit 6 and the valid bit at bit 1
		write_cp0("tlb entry lo", `MEM_CP0_ENTRY_LO, {6'b0, pfn, 4'b0, 1'b1, 1'b0});
		issue(make_bundle(OP_WRITE_TLB, '0, '0, '0, 5'd4, EXC_NONE, '0));
		wait_ready("tlb write", stalled);
		check_value("tlb write stall cycles", 1, stalled);

		issue(make_bundle(OP_STORE, vaddr, word, '0, 5'd6, EXC_NONE, '0));
		check_value("store stall", 1'b1, stall);
		wait_ready("store", stalled);
		check_value("store wb_addr", '0, wb_addr);

		issue(make_bundle(OP_LOAD, vaddr, '0, '0, 5'd11, EXC_NONE, '0));
		check_value("load stall", 1'b1, stall);
		wait_ready("load", stalled);
		check_value("load wb_addr", 5'd11, wb_addr);
		check_value("load wb_data", word, wb_data);
	endtask

	task automatic test_tlb_miss();
		logic [31:0] vaddr;
		logic [31:0] epc;
		logic [31:0] value;
		vaddr = 32'h7f0013a8;
		epc = 32'h00400120;
		issue(make_bundle(OP_LOAD, vaddr, '0, '0, 5'd12, EXC_NONE, epc));
		wait_flush("tlb miss");
		check_value("tlb miss stall", 1'b0, stall);
		check_value("tlb miss early jump", 1'b0, exc_jmp_flag);
		check_jump("tlb miss");
		read_cp0("tlb miss badvaddr", `MEM_CP0_BADVADDR, value);
		check_value("tlb miss badvaddr value", vaddr, value);
		read_cp0("tlb miss epc", `MEM_CP0_EPC, value);
		check_value("tlb miss epc value", epc, value);
	endtask

	task automatic test_interrupts();
		int i;
		logic [31:0] value;
		logic [31:0] cause;
		// user mode with IM bit 2 set while IE stays off
		write_cp0("interrupt mask", `MEM_CP0_STATUS, 32'h0000_0410);
		check_value("interrupt user mode", 1'b1, is_user_mode);
		int_req = 8'b0000_0100;
		for (i = 0; i < 3; i++) begin
			value = $random(seed);
			issue(make_bundle(OP_NONE, '0, '0, value, 5'd13, EXC_NONE, '0));
			check_value("masked interrupt flush", 1'b0, flush);
			check_value("masked interrupt wb_data", value, wb_data);
		end
		write_cp0("interrupt enable", `MEM_CP0_STATUS, 32'h0000_0411);
		issue(make_bundle(OP_NONE, '0, '0, 32'h0000_1234, 5'd14, EXC_NONE, 32'h00400200));
		check_value("interrupt flush", 1'b1, flush);
		check_jump("interrupt");
		// exception entry sets EXL, which forces kernel mode
		check_value("interrupt kernel mode", 1'b0, is_user_mode);
		int_req = '0;
		read_cp0("interrupt cause", `MEM_CP0_CAUSE, cause);
		check_value("interrupt cause code", EXC_INT, cause[6:2]);
		check_value("interrupt cause ip2", 1'b1, cause[10]);
	endtask

	task automatic test_carried_exception();
		logic [31:0] value;
		logic [31:0] epc;
		logic [31:0] readback;
		value = $random(seed);
		epc = 32'h00400340;
		issue(make_bundle(OP_NONE, '0, '0, value, 5'd7, EXC_NONE, '0));
		check_value("syscall prior wb_addr", 5'd7, wb_addr);
		issue(make_bundle(OP_NONE, '0, '0, 32'hdeadbeef, 5'd9, EXC_SYS, epc));
		check_value("syscall flush", 1'b1, flush);
		check_value("syscall wb_addr held", 5'd7, wb_addr);
		check_value("syscall wb_data held", value, wb_data);
		check_jump("syscall");
		read_cp0("syscall epc", `MEM_CP0_EPC, readback);
		check_value("syscall epc value", epc, readback);
		read_cp0("syscall cause", `MEM_CP0_CAUSE, readback);
		check_value("syscall cause code", EXC_SYS, readback[6:2]);
	endtask

	// #########################################################################
	// sequence

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'h56f8;
		rst = 1'b1;
		ex2mem = idle_bundle();
		int_req = '0;

		apply_reset();
		test_writeback();
		test_cp0_roundtrip();
		test_store_load();
		test_tlb_miss();
		test_interrupts();
		test_carried_exception();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- hw/cp0.sv
/*
 * coprocessor 0
 * status, cause, EPC, BadVAddr, TLB staging and count/compare registers,
 * with the timer interrupt and exception entry
 */
`include "mem_config.svh"

module cp0 import mem_pkg::*; (
	input  logic clk,
	input  logic rst,

	input  cp0_write_t write,
	input  exc_code_e exc_code,
	input  logic [31:0] epc,
	input  logic [31:0] badvaddr,
	input  logic [`MEM_INT_W-1:0] int_pending,

	output cp0_regs_t regs,
	output logic timer_int,

	output logic exc_jmp_flag,
	output logic [31:0] exc_jmp_dest
);

	logic [`MEM_TLB_IDX_W-1:0] index_r;
	logic [31:0] entry_lo_r;
	logic [31:0] entry_hi_r;
	logic [31:0] epc_r;
	logic [31:0] badvaddr_r;
	logic [31:0] count_r;
	logic [31:0] compare_r;
	logic [31:0] status_r;
	logic [31:0] cause_r;

	logic [`MEM_INT_W-1:0] int_all;

	assign int_all = int_pending | {timer_int, {(`MEM_INT_W-1){1'b0}}};

	// ########################################################################
	// control registers and timer

	always_ff @(posedge clk) begin
		if (rst) begin
			status_r <= '0;
			cause_r <= '0;
			count_r <= '0;
			compare_r <= '1;
			timer_int <= 1'b0;
			exc_jmp_flag <= 1'b0;
			exc_jmp_dest <= '0;
		end else begin
			count_r <= count_r + 32'd1;
			exc_jmp_flag <= 1'b0;
			exc_jmp_dest <= '0;

			if (count_r == compare_r)
				timer_int <= 1'b1;

			if (write.enable) begin
				case (write.addr)
					`MEM_CP0_COUNT: count_r <= write.data;
					`MEM_CP0_COMPARE: begin
						compare_r <= write.data;
						timer_int <= 1'b0;
					end
					`MEM_CP0_STATUS: status_r <= write.data;
					default: begin
					end
				endcase
			end

			if (exc_code != EXC_NONE) begin
				cause_r <= {16'b0, int_all, 1'b0, exc_code, 2'b0};
				status_r[1] <= 1'b1;
				exc_jmp_flag <= 1'b1;
				exc_jmp_dest <= `MEM_EXC_VECTOR;
			end
		end
	end

	// ########################################################################
	// software and exception data registers

	always_ff @(posedge clk) begin
		if (write.enable) begin
			case (write.addr)
				`MEM_CP0_INDEX: index_r <= write.data[`MEM_TLB_IDX_W-1:0];
				`MEM_CP0_ENTRY_LO: entry_lo_r <= write.data;
				`MEM_CP0_ENTRY_HI: entry_hi_r <= write.data;
				`MEM_CP0_EPC: epc_r <= write.data;
				default: begin
				end
			endcase
		end
		if (exc_code != EXC_NONE) begin
			epc_r <= epc;
			badvaddr_r <= badvaddr;
		end
	end

	always_comb begin
		regs = '0;
		regs[`MEM_CP0_INDEX] = 32'(index_r);
		regs[`MEM_CP0_ENTRY_LO] = entry_lo_r;
		regs[`MEM_CP0_BADVADDR] = badvaddr_r;
		regs[`MEM_CP0_COUNT] = count_r;
		regs[`MEM_CP0_ENTRY_HI] = entry_hi_r;
		regs[`MEM_CP0_COMPARE] = compare_r;
		regs[`MEM_CP0_STATUS] = status_r;
		regs[`MEM_CP0_CAUSE] = cause_r;
		regs[`MEM_CP0_EPC] = epc_r;
	end

endmodule

//--- hw/data_ram.sv
/*
 * data RAM
 * word-addressed memory behind a four-phase req/ack handshake,
 * acknowledging after a fixed number of wait cycles
 */
`include "mem_config.svh"

module data_ram import mem_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  ram_req_t req,
	input  logic valid,
	output logic ack,
	output logic [31:0] rdata
);

	localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
	localparam int CNT_W = $clog2(`MEM_RAM_WAIT + 1);

	logic [31:0] mem [`MEM_RAM_WORDS];
	logic [CNT_W-1:0] cnt;
	logic fire;

	// upper address bits are dropped so accesses wrap around the depth
	assign fire = valid && !ack && (cnt == CNT_W'(`MEM_RAM_WAIT - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			cnt <= '0;
		end else if (ack) begin
			if (!valid)
				ack <= 1'b0;
		end else if (fire) begin
			ack <= 1'b1;
			cnt <= '0;
		end else if (valid) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			if (req.write)
				mem[req.addr[IDX_W-1:0]] <= req.wdata;
			rdata <= mem[req.addr[IDX_W-1:0]];
		end
	end

endmodule

//--- hw/mem_config.svh
/*
 * memory subsystem configuration
 * widths, TLB geometry, coprocessor-0 register numbers, the exception
 * vector and data RAM sizing
 */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`define MEM_REGADDR_W 5
`define MEM_INT_W 8

`define MEM_TLB_N 4
`define MEM_TLB_IDX_W 2
`define MEM_VPN_W 20
`define MEM_PFN_W 20
`define MEM_PAGE_W 12
`define MEM_WADDR_W (`MEM_PFN_W + `MEM_PAGE_W - 2)

// coprocessor 0 register numbers
`define MEM_CP0_NREG 16
`define MEM_CP0_ADDR_W 4
`define MEM_CP0_INDEX 0
`define MEM_CP0_ENTRY_LO 2
`define MEM_CP0_BADVADDR 8
`define MEM_CP0_COUNT 9
`define MEM_CP0_ENTRY_HI 10
`define MEM_CP0_COMPARE 11
`define MEM_CP0_STATUS 12
`define MEM_CP0_CAUSE 13
`define MEM_CP0_EPC 14

`define MEM_EXC_VECTOR 32'h80000180

`define MEM_RAM_WORDS 1024
`define MEM_RAM_WAIT 2

`endif

//--- hw/mem_pkg.sv
/*
 * memory subsystem types
 * operation and exception encodings, and the bundles exchanged between
 * the stage, coprocessor 0, the MMU and the data RAM
 */
`include "mem_config.svh"

package mem_pkg;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_LOAD,
		OP_STORE,
		OP_READ_CP0,
		OP_WRITE_CP0,
		OP_WRITE_TLB
	} mem_op_e;

	// MIPS cause codes, the unused code 31 marks no exception
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_TLBL = 5'd2,
		EXC_TLBS = 5'd3,
		EXC_SYS  = 5'd8,
		EXC_NONE = 5'd31
	} exc_code_e;

	typedef struct packed {
		mem_op_e op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] alu_result;
		logic [`MEM_REGADDR_W-1:0] wb_addr;
		exc_code_e exc_code;
		logic [31:0] epc;
		logic [31:0] badvaddr;
	} ex2mem_t;

	typedef struct packed {
		logic [`MEM_VPN_W-1:0] vpn;
		logic [`MEM_PFN_W-1:0] pfn;
		logic valid;
	} tlb_entry_t;

	typedef struct packed {
		logic enable;
		logic [`MEM_TLB_IDX_W-1:0] index;
		tlb_entry_t entry;
	} tlb_write_t;

	typedef struct packed {
		mem_op_e op;
		logic [31:0] vaddr;
		logic [31:0] wdata;
	} mmu_req_t;

	typedef struct packed {
		logic write;
		logic [`MEM_WADDR_W-1:0] addr;
		logic [31:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic enable;
		logic [`MEM_CP0_ADDR_W-1:0] addr;
		logic [31:0] data;
	} cp0_write_t;

	typedef logic [`MEM_CP0_NREG-1:0][31:0] cp0_regs_t;

endpackage

//--- hw/mem_subsys.sv
/*
 * memory subsystem top
 * connects the memory stage, coprocessor 0, the MMU and the data RAM
 */
`include "mem_config.svh"

module mem_subsys import mem_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  ex2mem_t ex2mem,
	input  logic [`MEM_INT_W-1:0] int_req,
	output logic [`MEM_REGADDR_W-1:0] wb_addr,
	output logic [31:0] wb_data,
	output logic stall,
	output logic flush,
	output logic is_user_mode,
	output logic exc_jmp_flag,
	output logic [31:0] exc_jmp_dest
);

	mmu_req_t mmu_req;
	logic [31:0] mmu_rdata;
	logic mmu_busy;
	exc_code_e mmu_exc;
	tlb_write_t tlb_write;

	cp0_regs_t cp0_regs;
	logic cp0_timer_int;
	cp0_write_t cp0_write;
	exc_code_e cp0_exc;
	logic [31:0] cp0_epc;
	logic [31:0] cp0_badvaddr;

	ram_req_t ram_req;
	logic ram_valid;
	logic ram_ack;
	logic [31:0] ram_rdata;

	stage_mem u_stage (
		.clk(clk), .rst(rst),
		.ex2mem(ex2mem), .int_req(int_req),
		.wb_addr(wb_addr), .wb_data(wb_data),
		.stall(stall), .flush(flush), .is_user_mode(is_user_mode),
		.mmu_req(mmu_req), .mmu_rdata(mmu_rdata),
		.mmu_busy(mmu_busy), .mmu_exc(mmu_exc),
		.tlb_write(tlb_write),
		.cp0_regs(cp0_regs), .cp0_timer_int(cp0_timer_int),
		.cp0_write(cp0_write), .cp0_exc(cp0_exc),
		.cp0_epc(cp0_epc), .cp0_badvaddr(cp0_badvaddr)
	);

	cp0 u_cp0 (
		.clk(clk), .rst(rst),
		.write(cp0_write), .exc_code(cp0_exc),
		.epc(cp0_epc), .badvaddr(cp0_badvaddr),
		.int_pending(int_req),
		.regs(cp0_regs), .timer_int(cp0_timer_int),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest)
	);

	mmu u_mmu (
		.clk(clk), .rst(rst),
		.req(mmu_req), .tlb_write(tlb_write),
		.rdata(mmu_rdata), .busy(mmu_busy), .exc(mmu_exc),
		.ram_req(ram_req), .ram_valid(ram_valid),
		.ram_ack(ram_ack), .ram_rdata(ram_rdata)
	);

	data_ram u_ram (
		.clk(clk), .rst(rst),
		.req(ram_req), .valid(ram_valid),
		.ack(ram_ack), .rdata(ram_rdata)
	);

endmodule

//--- hw/mmu.sv
/*
 * memory management unit
 * fully associative TLB with parallel lookup, and a four-phase
 * request sequencer towards the data RAM
 */
`include "mem_config.svh"

module mmu import mem_pkg::*; (
	input  logic clk,
	input  logic rst,

	input  mmu_req_t req,
	input  tlb_write_t tlb_write,
	output logic [31:0] rdata,
	output logic busy,
	output exc_code_e exc,

	output ram_req_t ram_req,
	output logic ram_valid,
	input  logic ram_ack,
	input  logic [31:0] ram_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RELEASE
	} state_e;

	state_e state;

	tlb_entry_t tlb [`MEM_TLB_N];

	logic [`MEM_VPN_W-1:0] vpn;
	logic hit;
	logic [`MEM_PFN_W-1:0] hit_pfn;

	assign vpn = req.vaddr[31 -: `MEM_VPN_W];

	always_comb begin
		hit = 1'b0;
		hit_pfn = '0;
		for (int i = 0; i < `MEM_TLB_N; i++) begin
			if (tlb[i].valid && tlb[i].vpn == vpn) begin
				hit = 1'b1;
				hit_pfn = tlb[i].pfn;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MEM_TLB_N; i++)
				tlb[i].valid <= 1'b0;
		end else if (tlb_write.enable) begin
			tlb[tlb_write.index] <= tlb_write.entry;
		end
	end

	assign busy = (state != ST_IDLE);
	assign ram_valid = (state == ST_REQ);

	always_ff @(posedge clk) begin
		exc <= EXC_NONE;
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req.op == OP_LOAD || req.op == OP_STORE) begin
						if (hit) begin
							state <= ST_REQ;
							ram_req.write <= (req.op == OP_STORE);
							ram_req.addr <= {hit_pfn, req.vaddr[`MEM_PAGE_W-1:2]};
							ram_req.wdata <= req.wdata;
						end else begin
							// miss, the RAM is never touched
							exc <= (req.op == OP_LOAD) ? EXC_TLBL : EXC_TLBS;
						end
					end
				end
				ST_REQ: begin
					if (ram_ack) begin
						rdata <= ram_rdata;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: if (!ram_ack) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/stage_mem.sv
/*
 * memory access stage
 * arbitrates incoming exceptions, interrupts and the requested operation,
 * drives coprocessor 0, TLB writes and MMU accesses, and holds writeback
 */
`include "mem_config.svh"

module stage_mem import mem_pkg::*; (
	input  logic clk,
	input  logic rst,

	input  ex2mem_t ex2mem,
	input  logic [`MEM_INT_W-1:0] int_req,

	output logic [`MEM_REGADDR_W-1:0] wb_addr,
	output logic [31:0] wb_data,

	output logic stall,
	output logic flush,
	output logic is_user_mode,

	output mmu_req_t mmu_req,
	input  logic [31:0] mmu_rdata,
	input  logic mmu_busy,
	input  exc_code_e mmu_exc,

	output tlb_write_t tlb_write,

	input  cp0_regs_t cp0_regs,
	input  logic cp0_timer_int,
	output cp0_write_t cp0_write,
	output exc_code_e cp0_exc,
	output logic [31:0] cp0_epc,
	output logic [31:0] cp0_badvaddr
);

	typedef enum logic {
		ST_READY,
		ST_WAIT
	} state_e;

	state_e state;

	// set while the wait belongs to an MMU access, not to a CP0 or TLB write
	logic mmu_wait;
	// the MMU only answers from the cycle after the request pulse
	logic mmu_seen;

	logic [`MEM_REGADDR_W-1:0] wb_latch;
	logic [31:0] acc_addr;

	logic [31:0] status;
	logic [`MEM_INT_W-1:0] int_all;
	logic int_take;

	// ########################################################################
	// interrupt gating

	assign status = cp0_regs[`MEM_CP0_STATUS];
	assign int_all = int_req | {cp0_timer_int, {(`MEM_INT_W-1){1'b0}}};

	// no new interrupt while the previous exception is still being entered
	assign int_take = |(int_all & status[15:8]) && status[0] && !status[1] && !flush;

	assign is_user_mode = (status[4:3] == 2'b10) && !status[1];

	assign stall = (state == ST_WAIT);
	assign flush = (cp0_exc != EXC_NONE);

	// ########################################################################
	// control

	always_ff @(posedge clk) begin
		// one-cycle pulses fall back to idle unless set below
		mmu_req.op <= OP_NONE;
		cp0_write.enable <= 1'b0;
		tlb_write.enable <= 1'b0;
		cp0_exc <= EXC_NONE;

		if (rst) begin
			state <= ST_READY;
			wb_addr <= '0;
			mmu_wait <= 1'b0;
			mmu_seen <= 1'b0;
		end else begin
			case (state)
				ST_READY: begin
					cp0_epc <= ex2mem.epc;
					cp0_badvaddr <= ex2mem.badvaddr;
					acc_addr <= ex2mem.addr;
					// a store retires with register 0
					wb_latch <= (ex2mem.op == OP_LOAD) ? ex2mem.wb_addr : '0;

					if (ex2mem.exc_code != EXC_NONE) begin
						cp0_exc <= ex2mem.exc_code;
					end else if (int_take) begin
						cp0_exc <= EXC_INT;
					end else begin
						wb_addr <= ex2mem.wb_addr;
						wb_data <= ex2mem.alu_result;
						case (ex2mem.op)
							OP_READ_CP0:
								wb_data <= cp0_regs[ex2mem.addr[`MEM_CP0_ADDR_W-1:0]];
							OP_WRITE_CP0: begin
								state <= ST_WAIT;
								mmu_wait <= 1'b0;
								wb_addr <= '0;
								cp0_write.enable <= 1'b1;
								cp0_write.addr <= ex2mem.addr[`MEM_CP0_ADDR_W-1:0];
								cp0_write.data <= ex2mem.data;
							end
							OP_WRITE_TLB: begin
								state <= ST_WAIT;
								mmu_wait <= 1'b0;
								wb_addr <= '0;
								tlb_write.enable <= 1'b1;
								tlb_write.index <=
									cp0_regs[`MEM_CP0_INDEX][`MEM_TLB_IDX_W-1:0];
								tlb_write.entry.vpn <=
									cp0_regs[`MEM_CP0_ENTRY_HI][31 -: `MEM_VPN_W];
								tlb_write.entry.pfn <=
									cp0_regs[`MEM_CP0_ENTRY_LO][6 +: `MEM_PFN_W];
								tlb_write.entry.valid <= cp0_regs[`MEM_CP0_ENTRY_LO][1];
							end
							OP_LOAD, OP_STORE: begin
								state <= ST_WAIT;
								mmu_wait <= 1'b1;
								mmu_seen <= 1'b0;
								wb_addr <= '0;
								mmu_req.op <= ex2mem.op;
								mmu_req.vaddr <= ex2mem.addr;
								mmu_req.wdata <= ex2mem.data;
							end
							default: begin
							end
						endcase
					end
				end

				ST_WAIT: begin
					if (!mmu_wait) begin
						state <= ST_READY;
					end else if (!mmu_seen) begin
						mmu_seen <= 1'b1;
					end else if (mmu_exc != EXC_NONE) begin
						// translation fault, report the faulting address
						state <= ST_READY;
						cp0_exc <= mmu_exc;
						cp0_badvaddr <= acc_addr;
					end else if (!mmu_busy) begin
						state <= ST_READY;
						wb_addr <= wb_latch;
						wb_data <= mmu_rdata;
					end
				end

				default: state <= ST_READY;
			endcase
		end
	end

endmodule

//--- list.f
+incdir+hw
hw/mem_pkg.sv
hw/stage_mem.sv
hw/cp0.sv
hw/mmu.sv
hw/data_ram.sv
hw/mem_subsys.sv
dv/mem_subsys_tb.sv
